// File: src/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define XLEN 32

// register file geometry
`define REG_AW 5
`define NUM_REGS 32

// jal return address register
`define LINK_REG 31

// sequential pc increment
`define PC_STEP 4

`endif

// File: src/isa_pkg.sv
`include "mips_params.svh"

package isa_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // imm16 is [15:0], jump index is [25:0] of the same word
    typedef struct packed {
        logic [5:0]         opcode;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         sa;
        logic [5:0]         funct;
    } inst_fields_t;

endpackage

// File: src/pipe_pkg.sv
`include "mips_params.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_e;

    // SIMM sign-extended, ZIMM zero-extended
    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_ZIMM, SRC2_EIGHT} src2_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LW, MEM_SW} mem_op_e;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR} br_kind_e;

    typedef struct packed {
        alu_op_e            alu_op;
        src1_e              src1;
        src2_e              src2;
        mem_op_e            mem_op;
        logic               rf_we;
        logic [`REG_AW-1:0] rf_waddr;
    } ex_ctrl_t;

    // decode result of anything outside the subset
    localparam ex_ctrl_t CTRL_NOP = '{
        alu_op: ALU_ADD, src1: SRC1_RS, src2: SRC2_RT,
        mem_op: MEM_NONE, rf_we: 1'b0, rf_waddr: '0
    };

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        isa_pkg::inst_fields_t inst;
    } fetch_pkt_t;

    // result bus fed back from ex, mem and wb
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        isa_pkg::inst_fields_t inst;
        ex_ctrl_t              ctrl;
        logic [`XLEN-1:0]      rs_val;
        logic [`XLEN-1:0]      rt_val;
    } id_ex_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } branch_t;

endpackage

// File: src/id_stage_reg.sv
`timescale 1ns/10ps

module id_stage_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  pipe_pkg::fetch_pkt_t in_pkt,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic                hold,
    output pipe_pkg::fetch_pkt_t held_pkt,
    output logic                held_valid
);

    // room when empty or when the current one leaves this cycle
    assign in_ready = !held_valid || !hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (flush) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (!flush && in_ready && in_valid) begin
            held_pkt <= in_pkt;
        end
    end

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module inst_decoder (
    input  isa_pkg::inst_fields_t inst,
    output pipe_pkg::ex_ctrl_t    ctrl,
    output pipe_pkg::br_kind_e    br_kind
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [`REG_AW-1:0] LINK = `LINK_REG;

    // immediate-form writer into dst
    function automatic ex_ctrl_t imm_writer(alu_op_e op, src2_e src2,
                                            logic [`REG_AW-1:0] dst);
        return '{alu_op: op, src1: SRC1_RS, src2: src2,
                 mem_op: MEM_NONE, rf_we: 1'b1, rf_waddr: dst};
    endfunction

    always_comb begin
        ctrl = CTRL_NOP;
        br_kind = BR_NONE;
        case (inst.opcode)
            OP_SPECIAL: begin
                ctrl.rf_we = 1'b1;
                ctrl.rf_waddr = inst.rd;
                case (inst.funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLLV: ctrl.alu_op = ALU_SLL;
                    FN_SRLV: ctrl.alu_op = ALU_SRL;
                    FN_SRAV: ctrl.alu_op = ALU_SRA;
                    // constant shifts take sa as first operand
                    FN_SLL: begin
                        ctrl.alu_op = ALU_SLL;
                        ctrl.src1 = SRC1_SA;
                    end
                    FN_SRL: begin
                        ctrl.alu_op = ALU_SRL;
                        ctrl.src1 = SRC1_SA;
                    end
                    FN_SRA: begin
                        ctrl.alu_op = ALU_SRA;
                        ctrl.src1 = SRC1_SA;
                    end
                    FN_JR: begin
                        ctrl.rf_we = 1'b0;
                        br_kind = BR_JR;
                    end
                    default: ctrl.rf_we = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: ctrl = imm_writer(ALU_ADD, SRC2_SIMM, inst.rt);
            OP_SLTI:  ctrl = imm_writer(ALU_SLT, SRC2_SIMM, inst.rt);
            OP_SLTIU: ctrl = imm_writer(ALU_SLTU, SRC2_SIMM, inst.rt);
            OP_ANDI:  ctrl = imm_writer(ALU_AND, SRC2_ZIMM, inst.rt);
            OP_ORI:   ctrl = imm_writer(ALU_OR, SRC2_ZIMM, inst.rt);
            OP_XORI:  ctrl = imm_writer(ALU_XOR, SRC2_ZIMM, inst.rt);
            OP_LUI:   ctrl = imm_writer(ALU_LUI, SRC2_SIMM, inst.rt);
            OP_LW: begin
                ctrl = imm_writer(ALU_ADD, SRC2_SIMM, inst.rt);
                ctrl.mem_op = MEM_LW;
            end
            // address is base + offset with no register write
            OP_SW: begin
                ctrl.src2 = SRC2_SIMM;
                ctrl.mem_op = MEM_SW;
            end
            OP_BEQ: br_kind = BR_BEQ;
            OP_BNE: br_kind = BR_BNE;
            OP_J:   br_kind = BR_J;
            // link value is pc + 8
            OP_JAL: begin
                ctrl = '{alu_op: ALU_ADD, src1: SRC1_PC, src2: SRC2_EIGHT,
                         mem_op: MEM_NONE, rf_we: 1'b1, rf_waddr: LINK};
                br_kind = BR_JAL;
            end
            default: ;
        endcase
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2,
    input  pipe_pkg::fwd_t     wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wr_en;

    // r0 never gets written
    assign wr_en = wb.we && (wb.waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // same-cycle write-back bypass
    assign rdata1 = (wr_en && wb.waddr == raddr1) ? wb.wdata : regs[raddr1];
    assign rdata2 = (wr_en && wb.waddr == raddr2) ? wb.wdata : regs[raddr2];

endmodule

// File: src/operand_forward.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module operand_forward (
    input  logic [`REG_AW-1:0] rs,
    input  logic [`REG_AW-1:0] rt,
    input  logic [`XLEN-1:0]   rf_rs,
    input  logic [`XLEN-1:0]   rf_rt,
    input  pipe_pkg::fwd_t     ex_res,
    input  pipe_pkg::fwd_t     mem_res,
    input  logic               ex_load,
    output logic [`XLEN-1:0]   rs_val,
    output logic [`XLEN-1:0]   rt_val,
    output logic               hazard
);

    import pipe_pkg::*;

    logic rs_ex_hit;
    logic rt_ex_hit;

    // youngest result wins and wb comes in through rf_val
    function automatic logic [`XLEN-1:0] pick(logic [`REG_AW-1:0] addr,
                                              logic [`XLEN-1:0] rf_val,
                                              fwd_t ex, fwd_t mem);
        if (addr == '0) begin
            return '0;
        end else if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end
        return rf_val;
    endfunction

    assign rs_val = pick(rs, rf_rs, ex_res, mem_res);
    assign rt_val = pick(rt, rf_rt, ex_res, mem_res);

    // load data not ready until mem
    assign rs_ex_hit = (rs != '0) && (rs == ex_res.waddr);
    assign rt_ex_hit = (rt != '0) && (rt == ex_res.waddr);
    assign hazard = ex_load && ex_res.we && (rs_ex_hit || rt_ex_hit);

endmodule

// File: src/branch_unit.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module branch_unit (
    input  logic                  issue,
    input  logic [`XLEN-1:0]      pc,
    input  isa_pkg::inst_fields_t inst,
    input  pipe_pkg::br_kind_e    br_kind,
    input  logic [`XLEN-1:0]      rs_val,
    input  logic [`XLEN-1:0]      rt_val,
    output pipe_pkg::branch_t     br
);

    import pipe_pkg::*;

    localparam logic [`XLEN-1:0] STEP = `PC_STEP;

    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] br_off;
    logic [`XLEN-1:0] jmp_tgt;
    logic             eq;

    assign pc_next = pc + STEP;
    assign br_off = {{(`XLEN-18){inst[15]}}, inst[15:0], 2'b00};
    // keeps the region bits of the delay slot pc
    assign jmp_tgt = {pc_next[`XLEN-1 -: 4], inst[25:0], 2'b00};
    assign eq = (rs_val == rt_val);

    always_comb begin
        br.taken = 1'b0;
        br.target = pc_next + br_off;
        case (br_kind)
            BR_BEQ: br.taken = issue && eq;
            BR_BNE: br.taken = issue && !eq;
            BR_J, BR_JAL: begin
                br.taken = issue;
                br.target = jmp_tgt;
            end
            BR_JR: begin
                br.taken = issue;
                br.target = rs_val;
            end
            default: ;
        endcase
    end

endmodule

// File: src/id_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module id_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  pipe_pkg::fetch_pkt_t fetch_pkt,
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    output pipe_pkg::id_ex_t     ex_pkt,
    output logic                 ex_valid,
    input  logic                 ex_ready,
    input  pipe_pkg::fwd_t       ex_res,
    input  pipe_pkg::fwd_t       mem_res,
    input  pipe_pkg::fwd_t       wb_res,
    input  logic                 ex_load,
    output pipe_pkg::branch_t    br
);

    import pipe_pkg::*;

    fetch_pkt_t       held_pkt;
    logic             held_valid;
    logic             hold;
    logic             hazard;
    logic             issue;
    ex_ctrl_t         ctrl;
    br_kind_e         br_kind;
    logic [`XLEN-1:0] rf_rs;
    logic [`XLEN-1:0] rf_rt;
    logic [`XLEN-1:0] rs_val;
    logic [`XLEN-1:0] rt_val;

    // blocked by execute back-pressure or a load-use stall
    assign hold = !ex_ready || hazard;
    assign ex_valid = held_valid && !hazard;
    assign issue = ex_valid && ex_ready;

    id_stage_reg u_stage_reg (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_pkt     (fetch_pkt),
        .in_valid   (fetch_valid),
        .in_ready   (fetch_ready),
        .hold       (hold),
        .held_pkt   (held_pkt),
        .held_valid (held_valid)
    );

    inst_decoder u_decoder (
        .inst    (held_pkt.inst),
        .ctrl    (ctrl),
        .br_kind (br_kind)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (held_pkt.inst.rs),
        .raddr2 (held_pkt.inst.rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wb     (wb_res)
    );

    operand_forward u_forward (
        .rs      (held_pkt.inst.rs),
        .rt      (held_pkt.inst.rt),
        .rf_rs   (rf_rs),
        .rf_rt   (rf_rt),
        .ex_res  (ex_res),
        .mem_res (mem_res),
        .ex_load (ex_load),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .hazard  (hazard)
    );

    branch_unit u_branch (
        .issue   (issue),
        .pc      (held_pkt.pc),
        .inst    (held_pkt.inst),
        .br_kind (br_kind),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .br      (br)
    );

    assign ex_pkt = '{pc: held_pkt.pc, inst: held_pkt.inst, ctrl: ctrl,
                      rs_val: rs_val, rt_val: rt_val};

endmodule

// File: tests/id_stage_props.sv
`timescale 1ns/10ps

module id_stage_props (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              ex_valid,
    input logic              ex_ready,
    input logic              ex_load,
    input pipe_pkg::fwd_t    ex_res,
    input pipe_pkg::id_ex_t  ex_pkt,
    input pipe_pkg::branch_t br
);

    logic load_use;

    // execute-stage load writes a source of the held instruction
    assign load_use = ex_load && ex_res.we && (ex_res.waddr != '0) &&
        (ex_res.waddr == ex_pkt.inst.rs || ex_res.waddr == ex_pkt.inst.rt);

    // stage comes out of reset empty
    a_reset_empty: assert property (@(posedge clk) rst |=> !ex_valid)
        else $error("ex_valid high after reset");

    a_hazard_blocks: assert property (@(posedge clk) disable iff (rst)
        load_use |-> !ex_valid)
        else $error("ex_valid high during load-use hazard");

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && !ex_ready && !flush) |=> $stable(ex_pkt))
        else $error("ex_pkt changed under back-pressure");

    // redirect only with a real transfer
    a_taken_transfer: assert property (@(posedge clk) disable iff (rst)
        br.taken |-> (ex_valid && ex_ready))
        else $error("br.taken without transfer");

endmodule

bind id_stage id_stage_props u_props (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .ex_valid (ex_valid),
    .ex_ready (ex_ready),
    .ex_load  (ex_load),
    .ex_res   (ex_res),
    .ex_pkt   (ex_pkt),
    .br       (br)
);

// File: tests/tb_id_stage.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module tb_id_stage;

    import isa_pkg::*;
    import pipe_pkg::*;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       flush = 1'b0;
    fetch_pkt_t fetch_pkt = '0;
    logic       fetch_valid = 1'b0;
    logic       fetch_ready;
    id_ex_t     ex_pkt;
    logic       ex_valid;
    logic       ex_ready = 1'b1;
    fwd_t       ex_res = '0;
    fwd_t       mem_res = '0;
    fwd_t       wb_res = '0;
    logic       ex_load = 1'b0;
    branch_t    br;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int err_mark = 0;
    bit aborted = 1'b0;

    id_stage UUT (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_inst(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [4:0] sa, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_inst(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic give_up(string msg);
        $display("timeout: %s", msg);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(string name);
        tests++;
        $display("%s: done with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // hands one instruction to the stage and returns one ns after the accepting edge
    task automatic send(logic [31:0] pc, logic [31:0] inst);
        int n = 0;
        if (aborted) return;
        fetch_pkt.pc = pc;
        fetch_pkt.inst = inst_fields_t'(inst);
        fetch_valid = 1'b1;
        #1;
        while (!fetch_ready && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!fetch_ready) begin
            fetch_valid = 1'b0;
            give_up("stage never accepted an instruction");
            return;
        end
        step();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_valid();
        int n = 0;
        #1;
        while (!ex_valid && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ex_valid) give_up("ex_valid never rose");
    endtask

    task automatic write_reg(logic [4:0] addr, logic [31:0] val);
        wb_res = '{we: 1'b1, waddr: addr, wdata: val};
        step();
        wb_res.we = 1'b0;
    endtask

    task automatic decode_one(string name, logic [31:0] inst, alu_op_e alu, src1_e s1,
                              src2_e s2, mem_op_e mem, logic we, logic [4:0] waddr);
        send(32'h100, inst);
        wait_valid();
        check({name, " alu_op"}, ex_pkt.ctrl.alu_op, alu);
        check({name, " src1"}, ex_pkt.ctrl.src1, s1);
        check({name, " src2"}, ex_pkt.ctrl.src2, s2);
        check({name, " mem_op"}, ex_pkt.ctrl.mem_op, mem);
        check({name, " rf_we"}, ex_pkt.ctrl.rf_we, we);
        check({name, " rf_waddr"}, ex_pkt.ctrl.rf_waddr, waddr);
        step();
    endtask

    task automatic decode_classes();
        decode_one("add", r_inst(1, 2, 3, 0, 6'h20), ALU_ADD, SRC1_RS, SRC2_RT, MEM_NONE, 1, 3);
        decode_one("sll", r_inst(0, 2, 4, 5, 6'h00), ALU_SLL, SRC1_SA, SRC2_RT, MEM_NONE, 1, 4);
        decode_one("ori", i_inst(6'h0d, 1, 5, 16'h1234), ALU_OR, SRC1_RS, SRC2_ZIMM,
                   MEM_NONE, 1, 5);
        decode_one("lui", i_inst(6'h0f, 0, 6, 16'h8000), ALU_LUI, SRC1_RS, SRC2_SIMM,
                   MEM_NONE, 1, 6);
        decode_one("lw", i_inst(6'h23, 1, 7, 16'h0008), ALU_ADD, SRC1_RS, SRC2_SIMM,
                   MEM_LW, 1, 7);
        decode_one("sw", i_inst(6'h2b, 1, 7, 16'h0010), ALU_ADD, SRC1_RS, SRC2_SIMM,
                   MEM_SW, 0, 0);
        decode_one("jal", {6'h03, 26'h000_0040}, ALU_ADD, SRC1_PC, SRC2_EIGHT,
                   MEM_NONE, 1, 31);
        // opcode outside the subset
        decode_one("unknown", i_inst(6'h3f, 1, 2, 16'hffff), ALU_ADD, SRC1_RS, SRC2_RT,
                   MEM_NONE, 0, 0);
        end_test("decode");
    endtask

    task automatic regfile_readback();
        logic [31:0] v1 = $urandom;
        logic [31:0] v2 = $urandom;
        logic [31:0] v3 = $urandom;
        write_reg(8, v1);
        write_reg(9, v2);
        send(32'h200, r_inst(8, 9, 10, 0, 6'h20));
        wait_valid();
        check("rs_val", ex_pkt.rs_val, v1);
        check("rt_val", ex_pkt.rt_val, v2);
        step();
        send(32'h204, r_inst(11, 9, 10, 0, 6'h20));
        // write-back of r11 in the same cycle
        wb_res = '{we: 1'b1, waddr: 5'd11, wdata: v3};
        wait_valid();
        check("rs_val bypass", ex_pkt.rs_val, v3);
        step();
        wb_res.we = 1'b0;
        write_reg(0, v1);
        send(32'h208, r_inst(0, 0, 10, 0, 6'h20));
        wait_valid();
        check("rs_val r0", ex_pkt.rs_val, 0);
        check("rt_val r0", ex_pkt.rt_val, 0);
        step();
        end_test("regfile");
    endtask

    task automatic fwd_case(string name, logic [31:0] exp);
        send(32'h300, r_inst(13, 13, 2, 0, 6'h20));
        wait_valid();
        check({name, " rs_val"}, ex_pkt.rs_val, exp);
        check({name, " rt_val"}, ex_pkt.rt_val, exp);
        step();
    endtask

    task automatic forward_priority();
        logic [31:0] a = $urandom;
        logic [31:0] b = $urandom;
        logic [31:0] c = $urandom;
        ex_res = '{we: 1'b1, waddr: 5'd13, wdata: a};
        mem_res = '{we: 1'b1, waddr: 5'd13, wdata: b};
        wb_res = '{we: 1'b1, waddr: 5'd13, wdata: c};
        fwd_case("ex over mem", a);
        ex_res.we = 1'b0;
        fwd_case("mem over wb", b);
        mem_res.we = 1'b0;
        fwd_case("wb", c);
        wb_res.we = 1'b0;
        end_test("forwarding");
    endtask

    task automatic load_use_stall();
        logic [31:0] v = $urandom;
        logic [31:0] inst = r_inst(1, 14, 15, 0, 6'h20);
        ex_res = '{we: 1'b1, waddr: 5'd14, wdata: v};
        ex_load = 1'b1;
        send(32'h400, inst);
        for (int i = 0; i < 3; i++) begin
            #1;
            check("ex_valid stalled", ex_valid, 0);
            check("fetch_ready stalled", fetch_ready, 0);
            step();
        end
        ex_load = 1'b0;
        wait_valid();
        check("ex_pkt.inst", ex_pkt.inst, inst);
        check("ex_pkt.pc", ex_pkt.pc, 32'h400);
        check("rt_val", ex_pkt.rt_val, v);
        step();
        ex_res.we = 1'b0;
        end_test("load-use");
    endtask

    task automatic branch_case(string name, logic [31:0] pc, logic [31:0] inst,
                               logic exp_taken, logic [31:0] exp_target);
        send(pc, inst);
        wait_valid();
        check({name, " taken"}, br.taken, exp_taken);
        if (exp_taken) check({name, " target"}, br.target, exp_target);
        if (inst[31:26] == 6'h03) begin
            check({name, " rf_waddr"}, ex_pkt.ctrl.rf_waddr, 31);
            check({name, " rf_we"}, ex_pkt.ctrl.rf_we, 1);
        end
        step();
    endtask

    task automatic branch_targets();
        logic [31:0] v1 = $urandom;
        logic [31:0] v2 = v1 ^ 32'h1;
        logic [31:0] tgt = $urandom & 32'hffff_fffc;
        write_reg(8, v1);
        write_reg(9, v2);
        // pc + 4 - 16
        branch_case("beq eq", 32'h1000, i_inst(6'h04, 8, 8, 16'hfffc), 1, 32'h0ff4);
        branch_case("beq ne", 32'h1000, i_inst(6'h04, 8, 9, 16'h0010), 0, 0);
        branch_case("bne ne", 32'h2000, i_inst(6'h05, 8, 9, 16'h0010), 1, 32'h2044);
        branch_case("bne eq", 32'h2000, i_inst(6'h05, 9, 9, 16'h0010), 0, 0);
        // delay-slot pc sits in the next 256 MB region
        branch_case("j", 32'h4fff_fffc, {6'h02, 26'h012_3456}, 1, 32'h5048_d158);
        branch_case("jal", 32'h0000_3000, {6'h03, 26'h000_0100}, 1, 32'h0000_0400);
        ex_res = '{we: 1'b1, waddr: 5'd16, wdata: tgt};
        branch_case("jr", 32'h5000, r_inst(16, 0, 0, 0, 6'h08), 1, tgt);
        ex_res.we = 1'b0;
        end_test("branches");
    endtask

    task automatic backpressure_flush();
        id_ex_t saved;
        ex_ready = 1'b0;
        send(32'h600, r_inst(1, 2, 3, 0, 6'h21));
        wait_valid();
        saved = ex_pkt;
        step();
        fetch_pkt.pc = 32'h604;
        fetch_valid = 1'b1;
        for (int i = 0; i < 4; i++) begin
            #1;
            check("ex_valid held", ex_valid, 1);
            check("fetch_ready held", fetch_ready, 0);
            check("ex_pkt stable", ex_pkt == saved, 1);
            step();
        end
        flush = 1'b1;
        step();
        flush = 1'b0;
        fetch_valid = 1'b0;
        #1;
        check("ex_valid after flush", ex_valid, 0);
        ex_ready = 1'b1;
        step();
        end_test("back-pressure and flush");
    endtask

    initial begin
        void'($urandom(32'h3d0));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        check("ex_valid after reset", ex_valid, 0);
        check("br.taken after reset", br.taken, 0);
        check("fetch_ready after reset", fetch_ready, 1);
        end_test("reset");
        step();
        decode_classes();
        regfile_readback();
        forward_priority();
        load_use_stall();
        branch_targets();
        backpressure_flush();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/id_stage_reg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
tests/id_stage_props.sv
tests/tb_id_stage.sv

// File: Makefile
SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_id_stage: $(SRCS) flist.f
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_id_stage -o Vtb_id_stage

run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
